//--- rtl/video_adj_pkg.sv
// widths, types, register map and latency for the video colour-adjust design
`default_nettype none

package video_adj_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int PIX_W      = 8;
    localparam int RGB_W      = 3 * PIX_W;
    localparam int CONTRAST_W = 16;
    localparam int BRIGHT_W   = 9;
    localparam int WB_DW      = 32;
    localparam int WB_AW      = 2;

    // contrast is Q10.6
    localparam int COE_FRAC   = 6;
    localparam int PIPE_LAT   = 5;

    // arithmetic widths inside the pipeline
    localparam int DIFF_W     = PIX_W + 1;
    localparam int PROD_W     = DIFF_W + CONTRAST_W + 1;
    localparam int SCL_W      = PROD_W - COE_FRAC;
    localparam int SUM_W      = SCL_W + 1;
    localparam int PIX_MID    = 128;
    localparam int ROUND_ADD  = 1 << (COE_FRAC - 1);

    typedef logic [PIX_W-1:0]      pix_t;
    // R in 7:0, G in 15:8, B in 23:16
    typedef logic [RGB_W-1:0]      rgb_t;
    typedef logic [CONTRAST_W-1:0] contrast_t;
    // two's complement offset
    typedef logic [BRIGHT_W-1:0]   bright_t;
    typedef logic [WB_DW-1:0]      wb_data_t;
    typedef logic [WB_AW-1:0]      wb_adr_t;

    // ------------------------------
    // register map
    // ------------------------------
    localparam wb_adr_t   ADR_CONTRAST = 2'd0;
    localparam wb_adr_t   ADR_BRIGHT   = 2'd1;
    localparam wb_adr_t   ADR_ACTIVE   = 2'd2;
    localparam contrast_t CONTRAST_RST = 16'h0040;
    localparam bright_t   BRIGHT_RST   = 9'd0;

endpackage

`default_nettype wire

//--- rtl/video_if.sv
// video bundle interface: pixel word with de, hs and vs strobes
`timescale 1ns/1ps
`default_nettype none

interface video_if import video_adj_pkg::*; ();

    rgb_t pix;
    logic de;
    logic hs;
    logic vs;

    // producer side
    modport src (
        output pix, de, hs, vs
    );

    // consumer side
    modport snk (
        input pix, de, hs, vs
    );

endinterface

`default_nettype wire

//--- rtl/adj_csr.sv
// wishbone classic register slave, staging and frame-latched active coefficients
`timescale 1ns/1ps
`default_nettype none

module adj_csr import video_adj_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    // wishbone classic slave
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  wb_adr_t   wb_adr_i,
    input  wb_data_t  wb_dat_i,
    output wb_data_t  wb_dat_o,
    output logic      wb_ack_o,
    // frame sync from the pipeline input
    input  logic      vs_i,
    // active coefficients
    output contrast_t contrast_o,
    output bright_t   bright_o
);

    contrast_t stg_contrast;
    bright_t   stg_bright;
    wb_data_t  rd_data;
    logic      wb_req;
    logic      vs_q;
    logic      vs_rise;

    // new request only while ack is low
    assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign vs_rise = vs_i & ~vs_q;

    // ------------------------------
    // bus handshake
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_req;
        end
    end

    // staging registers, written on the ack edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            stg_contrast <= CONTRAST_RST;
            stg_bright   <= BRIGHT_RST;
        end else if (wb_req && wb_we_i) begin
            case (wb_adr_i)
                ADR_CONTRAST: stg_contrast <= wb_dat_i[CONTRAST_W-1:0];
                ADR_BRIGHT:   stg_bright   <= wb_dat_i[BRIGHT_W-1:0];
                default:      ;
            endcase
        end
    end

    always_comb begin
        case (wb_adr_i)
            ADR_CONTRAST: rd_data = {{(WB_DW-CONTRAST_W){1'b0}}, stg_contrast};
            ADR_BRIGHT:   rd_data = {{(WB_DW-BRIGHT_W){1'b0}}, stg_bright};
            ADR_ACTIVE:   rd_data = {{(WB_DW-BRIGHT_W-CONTRAST_W){1'b0}},
                                     bright_o, contrast_o};
            default:      rd_data = '0;
        endcase
    end

    // read data held while ack is high
    always_ff @(posedge clk) begin
        if (wb_req && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

    // ------------------------------
    // frame latching
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            vs_q <= 1'b0;
        end else begin
            vs_q <= vs_i;
        end
    end

    // a write on the same edge lands in staging only
    always_ff @(posedge clk) begin
        if (rst_i) begin
            contrast_o <= CONTRAST_RST;
            bright_o   <= BRIGHT_RST;
        end else if (vs_rise) begin
            contrast_o <= stg_contrast;
            bright_o   <= stg_bright;
        end
    end

    // ack only follows a request from the previous cycle
    a_ack_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))
        else $error("wb ack raised without cyc and stb");

    // single-cycle ack
    a_ack_single: assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb ack high for two cycles");

endmodule

`default_nettype wire

//--- rtl/bc_adjust.sv
// five-stage brightness/contrast pipeline with per-channel clamping
`timescale 1ns/1ps
`default_nettype none

module bc_adjust import video_adj_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  contrast_t contrast_i,
    input  bright_t   bright_i,
    video_if.snk      vid_in,
    video_if.src      vid_out
);

    // ------------------------------
    // per-channel datapath
    // ------------------------------
    logic signed [DIFF_W-1:0] s1_diff [3];
    logic signed [PROD_W-1:0] s2_prod [3];
    logic signed [SCL_W-1:0]  s3_scl  [3];
    logic signed [SUM_W-1:0]  s4_sum  [3];
    pix_t                     s5_pix  [3];

    // coefficients travel with the pixel
    contrast_t s1_con;
    bright_t   s1_bri;
    bright_t   s2_bri;
    bright_t   s3_bri;

    // strobe delay lines
    logic [PIPE_LAT-1:0] sr_de;
    logic [PIPE_LAT-1:0] sr_hs;
    logic [PIPE_LAT-1:0] sr_vs;

    // stage 1: centre on zero, capture coefficients
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            s1_diff[c] <= $signed({1'b0, vid_in.pix[c*PIX_W +: PIX_W]})
                          - $signed(DIFF_W'(PIX_MID));
        end
        s1_con <= contrast_i;
        s1_bri <= bright_i;
    end

    // stage 2: multiply, each channel by its own operand
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            s2_prod[c] <= s1_diff[c] * $signed({1'b0, s1_con});
        end
        s2_bri <= s1_bri;
    end

    // stage 3: round half up, drop the fraction
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            s3_scl[c] <= SCL_W'((s2_prod[c] + PROD_W'(ROUND_ADD)) >>> COE_FRAC);
        end
        s3_bri <= s2_bri;
    end

    // stage 4: back to unsigned range, add brightness
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            s4_sum[c] <= SUM_W'(s3_scl[c]) + SUM_W'(PIX_MID)
                         + SUM_W'(signed'(s3_bri));
        end
    end

    // stage 5: clamp to 0..255
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            if (rst_i) begin
                s5_pix[c] <= '0;
            end else if (s4_sum[c][SUM_W-1]) begin
                s5_pix[c] <= '0;
            end else if (|s4_sum[c][SUM_W-2:PIX_W]) begin
                s5_pix[c] <= '1;
            end else begin
                s5_pix[c] <= s4_sum[c][PIX_W-1:0];
            end
        end
    end

    // ------------------------------
    // timing strobes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sr_de <= '0;
            sr_hs <= '0;
            sr_vs <= '0;
        end else begin
            sr_de <= {sr_de[PIPE_LAT-2:0], vid_in.de};
            sr_hs <= {sr_hs[PIPE_LAT-2:0], vid_in.hs};
            sr_vs <= {sr_vs[PIPE_LAT-2:0], vid_in.vs};
        end
    end

    assign vid_out.pix = {s5_pix[2], s5_pix[1], s5_pix[0]};
    assign vid_out.de  = sr_de[PIPE_LAT-1];
    assign vid_out.hs  = sr_hs[PIPE_LAT-1];
    assign vid_out.vs  = sr_vs[PIPE_LAT-1];

    // de out matches de in after the full latency, once reset has flushed
    a_de_latency: assert property (@(posedge clk)
        (!rst_i) [*PIPE_LAT+1] |-> vid_out.de == $past(vid_in.de, PIPE_LAT))
        else $error("de_o does not follow de_i by the pipeline latency");

endmodule

`default_nettype wire

//--- rtl/video_adj_top.sv
// top level: register slave and colour-adjust pipeline with plain ports
`timescale 1ns/1ps
`default_nettype none

module video_adj_top import video_adj_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    // host register port
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_adr_t  wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    // video in
    input  rgb_t     pix_i,
    input  logic     de_i,
    input  logic     hs_i,
    input  logic     vs_i,
    // video out
    output rgb_t     pix_o,
    output logic     de_o,
    output logic     hs_o,
    output logic     vs_o
);

    contrast_t contrast;
    bright_t   bright;

    video_if vid_in ();
    video_if vid_out ();

    // ------------------------------
    // video bundles
    // ------------------------------
    assign vid_in.pix = pix_i;
    assign vid_in.de  = de_i;
    assign vid_in.hs  = hs_i;
    assign vid_in.vs  = vs_i;

    assign pix_o = vid_out.pix;
    assign de_o  = vid_out.de;
    assign hs_o  = vid_out.hs;
    assign vs_o  = vid_out.vs;

    adj_csr adj_csr_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .vs_i       (vs_i),
        .contrast_o (contrast),
        .bright_o   (bright)
    );

    bc_adjust bc_adjust_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .contrast_i (contrast),
        .bright_i   (bright),
        .vid_in     (vid_in.snk),
        .vid_out    (vid_out.src)
    );

endmodule

`default_nettype wire

//--- tb/tb_video_adj.sv
// testbench for video_adj_top with stimulus and expected values from the golden file
`timescale 1ns/1ps
`default_nettype none

module tb_video_adj import video_adj_pkg::*; ();

    localparam int WAIT_MAX = 50;

    logic     clk = 1'b0;
    logic     rst_i;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    wb_adr_t  wb_adr_i;
    wb_data_t wb_dat_i;
    wb_data_t wb_dat_o;
    logic     wb_ack_o;
    rgb_t     pix_i;
    logic     de_i;
    logic     hs_i;
    logic     vs_i;
    rgb_t     pix_o;
    logic     de_o;
    logic     hs_o;
    logic     vs_o;

    // expected output pixels in order of appearance
    rgb_t exp_q [$];

    // input strobes as seen on the last few falling edges
    logic [PIPE_LAT-1:0] de_hist = '0;
    logic [PIPE_LAT-1:0] hs_hist = '0;
    logic [PIPE_LAT-1:0] vs_hist = '0;

    video_adj_top video_adj_top_inst (.*);

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // ------------------------------
    // wishbone classic master
    // ------------------------------
    task automatic wb_transfer(input logic we, input wb_adr_t adr, input wb_data_t wdat,
                               output wb_data_t rdat);
        int n;
        n = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        next_cycle();
        while (!wb_ack_o) begin
            n++;
            if (n >= WAIT_MAX) begin
                stop_with_failure("wishbone ack did not arrive in time");
            end
            next_cycle();
        end
        // ack belongs in the cycle right after the request
        if (n != 0) begin
            stop_with_failure($sformatf("wishbone ack came %0d cycles late", n));
        end
        rdat = wb_dat_o;
        // request still present on the ack edge must not start another transfer
        next_cycle();
        check_value("wb_ack_o", wb_ack_o, 1'b0);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    // vs pulse then hs pulse with de held low
    task automatic frame_start();
        next_cycle();
        de_i = 1'b0;
        vs_i = 1'b1;
        next_cycle();
        vs_i = 1'b0;
        hs_i = 1'b1;
        next_cycle();
        hs_i = 1'b0;
    endtask

    // ------------------------------
    // output monitor
    // ------------------------------
    always @(negedge clk) begin
        if (!rst_i) begin
            check_value("de_o", de_o, de_hist[PIPE_LAT-1]);
            check_value("hs_o", hs_o, hs_hist[PIPE_LAT-1]);
            check_value("vs_o", vs_o, vs_hist[PIPE_LAT-1]);
            if (de_o) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("de_o is high but no pixel was expected");
                end else begin
                    check_value("pix_o", pix_o, exp_q.pop_front());
                end
            end
        end
        de_hist = {de_hist[PIPE_LAT-2:0], de_i};
        hs_hist = {hs_hist[PIPE_LAT-2:0], hs_i};
        vs_hist = {vs_hist[PIPE_LAT-2:0], vs_i};
    end

    initial begin
        int       fd;
        int       code;
        int       n;
        byte      cmd;
        string    line;
        wb_adr_t  adr;
        wb_data_t dat;
        wb_data_t rdat;
        rgb_t     pin;
        rgb_t     pexp;
        rst_i    = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        pix_i    = '0;
        de_i     = 1'b0;
        hs_i     = 1'b0;
        vs_i     = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_i = 1'b0;

        fd = $fopen("tb/video_adj_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the golden file tb/video_adj_golden.txt");
        end
        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            case (cmd)
                "#": code = $fgets(line, fd);
                "W": begin
                    code = $fscanf(fd, "%h %h", adr, dat);
                    next_cycle();
                    de_i = 1'b0;
                    wb_transfer(1'b1, adr, dat, rdat);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", adr, dat);
                    next_cycle();
                    de_i = 1'b0;
                    wb_transfer(1'b0, adr, '0, rdat);
                    check_value("wb_dat_o", rdat, dat);
                end
                "F": frame_start();
                "P": begin
                    code = $fscanf(fd, "%h %h", pin, pexp);
                    next_cycle();
                    pix_i = pin;
                    de_i  = 1'b1;
                    exp_q.push_back(pexp);
                end
                default: stop_with_failure($sformatf("unknown command %c in golden file", cmd));
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);

        // let the pipeline drain
        next_cycle();
        de_i = 1'b0;
        n = 0;
        while (exp_q.size() != 0) begin
            n++;
            if (n >= WAIT_MAX) begin
                stop_with_failure("expected pixels never appeared on the output");
            end
            next_cycle();
        end
        repeat (PIPE_LAT + 1) next_cycle();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/video_adj_golden.txt
# W adr data | R adr expected_data | F frame start | P pixel_in expected_pixel_out
# all fields hex, pixels as BBGGRR
P 000000 000000
P ffffff ffffff
P 123456 123456
R 2 00000040
R 3 00000000
W 0 00000060
W 1 00000010
R 0 00000060
R 1 00000010
R 2 00000040
P c0e0a0 c0e0a0
F
R 2 00100060
P 907f81 a88f92
P 5da340 5cc530
P 8010e0 9000ff
W 0 00000020
W 1 000001ec
P 907f81 a88f92
F
P 837f81 6e6c6d
P 7dff00 6bac2c
W 0 12340400
W 1 fffffe64
R 1 00000064
F
P 607f82 00d4ff
P 008180 00f4e4
W 1 0000019c
F
P ff7e80 ff001c
P 70857f 006c0c

//--- project.f
rtl/video_adj_pkg.sv
rtl/video_if.sv
rtl/adj_csr.sv
rtl/bc_adjust.sv
rtl/video_adj_top.sv
tb/tb_video_adj.sv
